// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := int_execute_tb
FILELIST  := int_execute.f
BUILD_DIR := obj_dir
RUN_FLAGS := +verilator+error+limit+100000
LOG       := sim.log

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG) || ! grep -q "Test OK" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/alu_decoder.sv ====
`timescale 1ns/1ps

module alu_decoder (
	input  logic                        clk_i,
	input  logic                        arst_n_i,
	input  logic                        valid_i,
	input  rv_isa_pkg::instr_u          instr_i,
	input  logic [rv_isa_pkg::XLEN-1:0] rs1_val_i,
	input  logic [rv_isa_pkg::XLEN-1:0] rs2_val_i,
	output alu_pkg::alu_operands_t      ops_o
);
	import rv_isa_pkg::*;
	import alu_pkg::*;

	alu_operands_t   ops_d;
	alu_op_e         op;
	logic [XLEN-1:0] b;
	logic [XLEN-1:0] imm_sext;
	logic [XLEN-1:0] imm_shamt;
	logic            legal;
	logic            alt_f7;
	logic            base_f7;

	assign imm_sext  = {{(XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};
	assign imm_shamt = {{(XLEN-5){1'b0}}, instr_i.i.imm[4:0]};

	// For OP-IMM these bits are imm[11:5], which shifts treat as funct7.
	assign alt_f7  = instr_i.r.funct7 == FUNCT7_ALT;
	assign base_f7 = instr_i.r.funct7 == 7'b0000000;

	always_comb begin
		op    = ADD;
		b     = rs2_val_i;
		legal = 1'b0;
		case (instr_i.r.opcode)
			OPC_OP: begin
				legal = base_f7;
				case (instr_i.r.funct3)
					FUNCT3_ADD: begin
						op    = alt_f7 ? SUB : ADD;
						legal = base_f7 | alt_f7;
					end
					FUNCT3_SR: begin
						op    = alt_f7 ? SRA : SRL;
						legal = base_f7 | alt_f7;
					end
					FUNCT3_SLL:  op = SLL;
					FUNCT3_SLT:  op = SLT;
					FUNCT3_SLTU: op = SLTU;
					FUNCT3_XOR:  op = XOR;
					FUNCT3_OR:   op = OR;
					FUNCT3_AND:  op = AND;
					default:     op = ADD;
				endcase
			end
			OPC_OP_IMM: begin
				b     = imm_sext;
				legal = 1'b1;
				case (instr_i.i.funct3)
					FUNCT3_SLL: begin
						op    = SLL;
						b     = imm_shamt;
						legal = base_f7;
					end
					FUNCT3_SR: begin
						op    = alt_f7 ? SRA : SRL; // SRAI is the only alternate form.
						b     = imm_shamt;
						legal = base_f7 | alt_f7;
					end
					FUNCT3_SLT:  op = SLT;
					FUNCT3_SLTU: op = SLTU;
					FUNCT3_XOR:  op = XOR;
					FUNCT3_OR:   op = OR;
					FUNCT3_AND:  op = AND;
					default:     op = ADD;
				endcase
			end
			default: legal = 1'b0;
		endcase
	end

	always_comb begin
		ops_d = '0;
		if (valid_i) begin
			ops_d.valid   = legal;
			ops_d.illegal = !legal;
			if (legal) begin
				ops_d.op = op;
				ops_d.a  = rs1_val_i;
				ops_d.b  = b;
				ops_d.rd = instr_i.r.rd;
			end
		end
	end

	// Pipeline stage one.
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			ops_o <= '0;
		else
			ops_o <= ops_d;
	end

endmodule

// ==== hw/alu_pkg.sv ====
package alu_pkg;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		SLT,
		SLTU,
		AND,
		OR,
		XOR,
		SLL,
		SRL,
		SRA
	} alu_op_e;

	// Decoded operands held in pipeline stage one.
	typedef struct packed {
		logic                          valid;
		logic                          illegal;
		alu_op_e                       op;
		logic [rv_isa_pkg::XLEN-1:0]   a;
		logic [rv_isa_pkg::XLEN-1:0]   b;
		logic [4:0]                    rd;
	} alu_operands_t;

	// Result held in pipeline stage two.
	typedef struct packed {
		logic                          valid;
		logic                          illegal;
		logic [4:0]                    rd;
		logic [rv_isa_pkg::XLEN-1:0]   value;
	} alu_result_t;

endpackage

// ==== hw/int_execute.sv ====
`timescale 1ns/1ps

module int_execute (
	input  logic                        clk_i,
	input  logic                        arst_n_i,
	input  logic                        valid_i,
	input  rv_isa_pkg::instr_u          instr_i,
	input  logic [rv_isa_pkg::XLEN-1:0] rs1_val_i,
	input  logic [rv_isa_pkg::XLEN-1:0] rs2_val_i,
	output logic                        valid_o,
	output logic                        illegal_o,
	output logic [4:0]                  rd_o,
	output logic [rv_isa_pkg::XLEN-1:0] result_o
);
	import alu_pkg::*;

	alu_operands_t               ops_q;
	logic [rv_isa_pkg::XLEN-1:0] add_res;
	logic [rv_isa_pkg::XLEN-1:0] ls_res;
	alu_result_t                 res_q;

	alu_decoder i_decoder (
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.valid_i   (valid_i),
		.instr_i   (instr_i),
		.rs1_val_i (rs1_val_i),
		.rs2_val_i (rs2_val_i),
		.ops_o     (ops_q)
	);

	// Both units work on the same stage one operands.
	ripple_adder i_adder (
		.ops_i (ops_q),
		.sum_o (add_res)
	);

	logic_shift_unit i_logic_shift (
		.ops_i (ops_q),
		.res_o (ls_res)
	);

	result_select i_select (
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.ops_i     (ops_q),
		.add_res_i (add_res),
		.ls_res_i  (ls_res),
		.res_o     (res_q)
	);

	assign valid_o   = res_q.valid;
	assign illegal_o = res_q.illegal;
	assign rd_o      = res_q.rd;
	assign result_o  = res_q.value;

endmodule

// ==== hw/logic_shift_unit.sv ====
`timescale 1ns/1ps

module logic_shift_unit (
	input  alu_pkg::alu_operands_t      ops_i,
	output logic [rv_isa_pkg::XLEN-1:0] res_o
);
	import rv_isa_pkg::*;
	import alu_pkg::*;

	logic [$clog2(XLEN)-1:0] shamt;
	logic [XLEN-1:0]         sra_res;

	// Only the low five bits of b give the shift amount.
	assign shamt   = ops_i.b[$clog2(XLEN)-1:0];
	assign sra_res = $signed(ops_i.a) >>> shamt;

	always_comb begin
		case (ops_i.op)
			AND:     res_o = ops_i.a & ops_i.b;
			OR:      res_o = ops_i.a | ops_i.b;
			XOR:     res_o = ops_i.a ^ ops_i.b;
			SLL:     res_o = ops_i.a << shamt;
			SRL:     res_o = ops_i.a >> shamt;
			SRA:     res_o = sra_res;
			default: res_o = '0; // Adder operations are taken from the other unit.
		endcase
	end

endmodule

// ==== hw/result_select.sv ====
`timescale 1ns/1ps

module result_select (
	input  logic                        clk_i,
	input  logic                        arst_n_i,
	input  alu_pkg::alu_operands_t      ops_i,
	input  logic [rv_isa_pkg::XLEN-1:0] add_res_i,
	input  logic [rv_isa_pkg::XLEN-1:0] ls_res_i,
	output alu_pkg::alu_result_t        res_o
);
	import rv_isa_pkg::*;
	import alu_pkg::*;

	alu_result_t     res_d;
	logic            use_adder;
	logic [XLEN-1:0] value;

	assign use_adder = (ops_i.op == ADD) || (ops_i.op == SUB) ||
	                   (ops_i.op == SLT) || (ops_i.op == SLTU);
	assign value     = use_adder ? add_res_i : ls_res_i;

	always_comb begin
		res_d         = '0;
		res_d.valid   = ops_i.valid;
		res_d.illegal = ops_i.illegal;
		// Illegal and idle slots leave rd and value at zero.
		if (ops_i.valid) begin
			res_d.rd    = ops_i.rd;
			res_d.value = value;
		end
	end

	// Pipeline stage two.
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			res_o <= '0;
		else
			res_o <= res_d;
	end

endmodule

// ==== hw/ripple_adder.sv ====
`timescale 1ns/1ps

module ripple_adder (
	input  alu_pkg::alu_operands_t      ops_i,
	output logic [rv_isa_pkg::XLEN-1:0] sum_o
);
	import rv_isa_pkg::*;
	import alu_pkg::*;

	logic            sub;
	logic [XLEN-1:0] b_in;
	logic [XLEN-1:0] sum;
	logic            overflow;
	logic            lt_signed;
	logic            lt_unsigned;

	// Subtract and both compares compute a - b as a + ~b + 1.
	assign sub  = (ops_i.op == SUB) || (ops_i.op == SLT) || (ops_i.op == SLTU);
	assign b_in = ops_i.b ^ {XLEN{sub}};

	for (genvar i = 0; i < XLEN; i++) begin : g_bit
		logic cin;
		logic cout;

		if (i == 0) begin : g_lsb
			assign cin = sub;
		end else begin : g_chain
			assign cin = g_bit[i-1].cout;
		end

		assign sum[i] = ops_i.a[i] ^ b_in[i] ^ cin;
		assign cout   = (ops_i.a[i] & b_in[i]) | ((ops_i.a[i] ^ b_in[i]) & cin);
	end

	// Carry into and out of the sign bit differ on signed overflow.
	assign overflow    = g_bit[XLEN-1].cin ^ g_bit[XLEN-1].cout;
	assign lt_signed   = sum[XLEN-1] ^ overflow;
	assign lt_unsigned = ~g_bit[XLEN-1].cout; // No carry out means a borrow.

	always_comb begin
		case (ops_i.op)
			SLT:     sum_o = {{(XLEN-1){1'b0}}, lt_signed};
			SLTU:    sum_o = {{(XLEN-1){1'b0}}, lt_unsigned};
			default: sum_o = sum;
		endcase
	end

endmodule

// ==== hw/rv_isa_pkg.sv ====
package rv_isa_pkg;

	localparam int XLEN = 32;

	// Major opcodes handled by the execute stage.
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

	localparam logic [2:0] FUNCT3_ADD  = 3'b000;
	localparam logic [2:0] FUNCT3_SLL  = 3'b001;
	localparam logic [2:0] FUNCT3_SLT  = 3'b010;
	localparam logic [2:0] FUNCT3_SLTU = 3'b011;
	localparam logic [2:0] FUNCT3_XOR  = 3'b100;
	localparam logic [2:0] FUNCT3_SR   = 3'b101; // SRL and SRA share this code.
	localparam logic [2:0] FUNCT3_OR   = 3'b110;
	localparam logic [2:0] FUNCT3_AND  = 3'b111;

	// Selects SUB instead of ADD and SRA instead of SRL.
	localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rtype_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} itype_t;

	// The same instruction word seen as register-register or register-immediate.
	typedef union packed {
		rtype_t r;
		itype_t i;
	} instr_u;

endpackage

// ==== int_execute.f ====
hw/rv_isa_pkg.sv
hw/alu_pkg.sv
hw/alu_decoder.sv
hw/ripple_adder.sv
hw/logic_shift_unit.sv
hw/result_select.sv
hw/int_execute.sv
tb/int_execute_assert.sv
tb/int_execute_tb.sv

// ==== tb/int_execute_assert.sv ====
`timescale 1ns/1ps

module int_execute_assert (
	input logic                        clk_i,
	input logic                        arst_n_i,
	input logic                        valid_i,
	input logic [rv_isa_pkg::XLEN-1:0] instr_i,
	input logic [rv_isa_pkg::XLEN-1:0] rs1_val_i,
	input logic [rv_isa_pkg::XLEN-1:0] rs2_val_i,
	input logic                        valid_o,
	input logic                        illegal_o,
	input logic [4:0]                  rd_o,
	input logic [rv_isa_pkg::XLEN-1:0] result_o
);
	import rv_isa_pkg::*;
	import alu_pkg::*;

	alu_result_t exp_d;
	alu_result_t exp_q1;
	alu_result_t exp_q2;
	int unsigned err_valid = 0;
	int unsigned err_illegal = 0;
	int unsigned err_value = 0;
	int unsigned err_rd = 0;
	int unsigned err_quiet = 0;
	int unsigned fail_cnt;

	assign fail_cnt = err_valid + err_illegal + err_value + err_rd + err_quiet;

	// RV32I semantics of OP and OP-IMM, taken straight from the raw instruction bits.
	function automatic alu_result_t expected_result(input logic v, input logic [XLEN-1:0] w,
			input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		alu_result_t     r;
		logic [6:0]      opc;
		logic [6:0]      f7;
		logic [2:0]      f3;
		logic [XLEN-1:0] opnd;
		logic [4:0]      sh;
		logic            ok;
		logic            alt;
		opc  = w[6:0];
		f3   = w[14:12];
		f7   = w[31:25];
		alt  = f7 == FUNCT7_ALT;
		r    = '0;
		opnd = b;
		ok   = 1'b0;
		if (opc == OPC_OP) begin
			ok = (f7 == 7'd0) || (alt && (f3 == FUNCT3_ADD || f3 == FUNCT3_SR));
		end else if (opc == OPC_OP_IMM) begin
			opnd = {{(XLEN-12){w[31]}}, w[31:20]}; // Sign-extended I-type immediate.
			if (f3 == FUNCT3_SLL)
				ok = f7 == 7'd0;
			else if (f3 == FUNCT3_SR)
				ok = (f7 == 7'd0) || alt;
			else
				ok = 1'b1;
		end
		sh = opnd[4:0]; // For immediate shifts this is the shamt field.
		if (v && !ok) begin
			r.illegal = 1'b1;
		end else if (v) begin
			r.valid = 1'b1;
			r.rd    = w[11:7];
			case (f3)
				FUNCT3_ADD:  r.value = (opc == OPC_OP && alt) ? a - opnd : a + opnd;
				FUNCT3_SLL:  r.value = a << sh;
				FUNCT3_SLT:  r.value = {{(XLEN-1){1'b0}}, $signed(a) < $signed(opnd)};
				FUNCT3_SLTU: r.value = {{(XLEN-1){1'b0}}, a < opnd};
				FUNCT3_XOR:  r.value = a ^ opnd;
				FUNCT3_SR: begin
					if (alt)
						r.value = $signed(a) >>> sh;
					else
						r.value = a >> sh;
				end
				FUNCT3_OR:   r.value = a | opnd;
				default:     r.value = a & opnd;
			endcase
		end
		return r;
	endfunction

	always_comb exp_d = expected_result(valid_i, instr_i, rs1_val_i, rs2_val_i);

	// Two stages of delay to line up with the DUT latency.
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			exp_q1 <= '0;
			exp_q2 <= '0;
		end else begin
			exp_q1 <= exp_d;
			exp_q2 <= exp_q1;
		end
	end

	a_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		valid_o == exp_q2.valid)
		else begin
			err_valid++;
			$error("ERR %0t: valid_o is %b, expected %b", $time,
				$sampled(valid_o), $sampled(exp_q2.valid));
		end

	a_illegal: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		illegal_o == exp_q2.illegal)
		else begin
			err_illegal++;
			$error("ERR %0t: illegal_o is %b, expected %b", $time,
				$sampled(illegal_o), $sampled(exp_q2.illegal));
		end

	a_value: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		valid_o |-> result_o == exp_q2.value)
		else begin
			err_value++;
			$error("ERR %0t: result_o is %h, expected %h", $time,
				$sampled(result_o), $sampled(exp_q2.value));
		end

	a_rd: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		valid_o |-> rd_o == exp_q2.rd)
		else begin
			err_rd++;
			$error("ERR %0t: rd_o is %0d, expected %0d", $time,
				$sampled(rd_o), $sampled(exp_q2.rd));
		end

	// Idle and illegal slots carry zero rd and result.
	a_quiet: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		!valid_o |-> (result_o == '0 && rd_o == '0))
		else begin
			err_quiet++;
			$error("ERR %0t: rd_o %0d and result_o %h not zero without valid_o", $time,
				$sampled(rd_o), $sampled(result_o));
		end

endmodule

// ==== tb/int_execute_tb.sv ====
`timescale 1ns/1ps

module int_execute_tb;
	import rv_isa_pkg::*;

	logic        clk;
	logic        arst_n;
	logic        valid;
	logic [31:0] instr;
	logic [31:0] rs1_val;
	logic [31:0] rs2_val;
	logic        out_valid;
	logic        out_illegal;
	logic [4:0]  out_rd;
	logic [31:0] out_result;

	logic [31:0] corners [5];
	logic [11:0] imm_corners [5];
	int unsigned other_errs;
	int unsigned base_assert;
	int unsigned base_other;
	int unsigned tests_run;
	int unsigned tests_failed;

	int_execute i_dut (
		.clk_i     (clk),
		.arst_n_i  (arst_n),
		.valid_i   (valid),
		.instr_i   (instr),
		.rs1_val_i (rs1_val),
		.rs2_val_i (rs2_val),
		.valid_o   (out_valid),
		.illegal_o (out_illegal),
		.rd_o      (out_rd),
		.result_o  (out_result)
	);

	bind int_execute int_execute_assert i_chk (
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.valid_i   (valid_i),
		.instr_i   (instr_i),
		.rs1_val_i (rs1_val_i),
		.rs2_val_i (rs2_val_i),
		.valid_o   (valid_o),
		.illegal_o (illegal_o),
		.rd_o      (rd_o),
		.result_o  (result_o)
	);

	always #5 clk = ~clk;

	// Index 0 to 9 walks ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND.
	function automatic logic [31:0] encode_rtype(input int k, input logic [4:0] rd);
		logic [6:0] f7;
		logic [2:0] f3;
		f7 = (k == 1 || k == 7) ? FUNCT7_ALT : 7'd0;
		case (k)
			0, 1:    f3 = FUNCT3_ADD;
			2:       f3 = FUNCT3_SLL;
			3:       f3 = FUNCT3_SLT;
			4:       f3 = FUNCT3_SLTU;
			5:       f3 = FUNCT3_XOR;
			6, 7:    f3 = FUNCT3_SR;
			8:       f3 = FUNCT3_OR;
			default: f3 = FUNCT3_AND;
		endcase
		return {f7, 5'($urandom), 5'($urandom), f3, rd, OPC_OP};
	endfunction

	// Index 0 to 8 walks ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI.
	function automatic logic [31:0] encode_itype(input int k, input logic [11:0] imm,
			input logic [4:0] rd);
		logic [2:0]  f3;
		logic [11:0] imm_v;
		imm_v = imm;
		case (k)
			0:       f3 = FUNCT3_ADD;
			1:       f3 = FUNCT3_SLT;
			2:       f3 = FUNCT3_SLTU;
			3:       f3 = FUNCT3_XOR;
			4:       f3 = FUNCT3_OR;
			5:       f3 = FUNCT3_AND;
			6:       f3 = FUNCT3_SLL;
			default: f3 = FUNCT3_SR;
		endcase
		if (k >= 6)
			imm_v = {(k == 8) ? FUNCT7_ALT : 7'd0, imm[4:0]};
		return {imm_v, 5'($urandom), f3, rd, OPC_OP_IMM};
	endfunction

	function automatic logic [31:0] random_legal_instr(input logic [4:0] rd);
		if ($urandom_range(0, 1) == 1)
			return encode_rtype(int'($urandom_range(0, 9)), rd);
		return encode_itype(int'($urandom_range(0, 8)), 12'($urandom), rd);
	endfunction

	task automatic drive(input logic v, input logic [31:0] w, input logic [31:0] a,
			input logic [31:0] b);
		@(posedge clk);
		valid   <= v;
		instr   <= w;
		rs1_val <= a;
		rs2_val <= b;
	endtask

	// Garbage on the operand inputs must not leak out while valid is low.
	task automatic idle(input int cycles);
		for (int c = 0; c < cycles; c++)
			drive(1'b0, $urandom, $urandom, $urandom);
	endtask

	task automatic wait_output(input int limit);
		int   n;
		logic seen;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < limit) begin
			@(negedge clk);
			seen = out_valid || out_illegal;
			n++;
		end
		if (!seen) begin
			$display("Timeout: no valid_o or illegal_o within %0d cycles of the strobe", limit);
			other_errs++;
		end
	endtask

	task automatic run_one(input logic [31:0] w, input logic [31:0] a, input logic [31:0] b);
		drive(1'b1, w, a, b);
		idle(1);
		wait_output(8);
	endtask

	task automatic start_test();
		base_assert = i_dut.i_chk.fail_cnt;
		base_other  = other_errs;
	endtask

	task automatic finish_test(input string name);
		int unsigned errs;
		idle(4); // Let the last results reach the checks.
		errs = (i_dut.i_chk.fail_cnt - base_assert) + (other_errs - base_other);
		tests_run++;
		if (errs == 0) begin
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errs);
		end
	endtask

	initial begin
		logic [31:0] w;
		int          count;
		int          n;
		void'($urandom(32'hc634_17ad));
		clk          = 1'b0;
		arst_n       = 1'b0;
		valid        = 1'b0;
		instr        = '0;
		rs1_val      = '0;
		rs2_val      = '0;
		other_errs   = 0;
		tests_run    = 0;
		tests_failed = 0;
		corners      = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff,
			32'h0000_0001};
		imm_corners  = '{12'h000, 12'hfff, 12'h800, 12'h7ff, 12'h001};
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;

		start_test();
		idle(10);
		finish_test("reset_idle");

		start_test();
		for (int k = 0; k < 10; k++) begin
			for (int i = 0; i < 5; i++)
				for (int j = 0; j < 5; j++)
					run_one(encode_rtype(k, 5'(i * 5 + j + 1)), corners[i], corners[j]);
			for (int r = 0; r < 20; r++)
				run_one(encode_rtype(k, 5'($urandom)), $urandom, $urandom);
		end
		finish_test("r_type");

		start_test();
		for (int k = 0; k < 9; k++) begin
			for (int i = 0; i < 5; i++)
				for (int j = 0; j < 5; j++)
					run_one(encode_itype(k, imm_corners[j], 5'(i + 1)), corners[i], $urandom);
			for (int r = 0; r < 20; r++)
				run_one(encode_itype(k, 12'($urandom), 5'($urandom)), $urandom, $urandom);
		end
		finish_test("i_type");

		// One strobe per cycle, so two instructions are always in flight.
		start_test();
		count = 0;
		for (int r = 0; r < 32; r++) begin
			drive(1'b1, random_legal_instr(5'(r)), $urandom, $urandom);
			@(negedge clk);
			if (out_valid)
				count++;
		end
		n = 0;
		while (count < 32 && n < 8) begin
			idle(1);
			@(negedge clk);
			if (out_valid)
				count++;
			n++;
		end
		if (count != 32) begin
			$display("Back-to-back run delivered only %0d of 32 results", count);
			other_errs++;
		end
		finish_test("back_to_back");

		start_test();
		run_one({25'($urandom), 7'b0000011}, $urandom, $urandom); // Load.
		run_one({25'($urandom), 7'b0100011}, $urandom, $urandom); // Store.
		run_one({25'($urandom), 7'b1100011}, $urandom, $urandom);
		run_one({25'($urandom), 7'b0110111}, $urandom, $urandom);
		run_one({25'($urandom), 7'b1101111}, $urandom, $urandom);
		run_one(32'h0000_0000, $urandom, $urandom);
		run_one({7'b0000001, 10'($urandom), FUNCT3_ADD, 5'd3, OPC_OP}, $urandom, $urandom);
		run_one({FUNCT7_ALT, 10'($urandom), FUNCT3_XOR, 5'd4, OPC_OP}, $urandom, $urandom);
		run_one({FUNCT7_ALT, 10'($urandom), FUNCT3_SLL, 5'd5, OPC_OP_IMM}, $urandom, $urandom);
		run_one({7'b0000001, 10'($urandom), FUNCT3_SR, 5'd6, OPC_OP_IMM}, $urandom, $urandom);
		finish_test("illegal");

		start_test();
		for (int r = 0; r < 400; r++) begin
			if ($urandom_range(0, 3) == 0)
				w = $urandom;
			else
				w = random_legal_instr(5'($urandom));
			drive(1'($urandom), w, $urandom, $urandom);
		end
		finish_test("random_mix");

		$display("Summary: %0d tests, %0d passed, %0d failed, %0d assertion errors, %0d other errors",
			tests_run, tests_run - tests_failed, tests_failed, i_dut.i_chk.fail_cnt, other_errs);
		if (tests_failed == 0 && other_errs == 0 && i_dut.i_chk.fail_cnt == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule
